//--- list.f
+incdir+src
src/uart_echo_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/line_buffer.sv
src/echo_control.sv
src/uart_echo_top.sv
sim/uart_echo_sva.sv
sim/tb_uart_echo.sv

//--- sim/tb_uart_echo.sv
// Testbench for the UART echo subsystem. Sends bursts on the serial input,
// decodes the echo on the serial output and compares it with the line
// that should come back: the burst cut to 62 bytes, then two ampersands.
`timescale 1ns/1ns
`default_nettype none

`include "uart_echo_consts.svh"

module tb_uart_echo;

	localparam int CPB = `UART_CLKS_PER_BIT;
	localparam int KEEP = `ECHO_BUF_DEPTH - 2;
	localparam logic [7:0] AMP = "&";
	localparam int QUIET_CLKS = 500;
	localparam int GAP_CLKS = 100;
	localparam int SETTLE_CLKS = 200;
	// 87 frames sent and 91 echoed over the six tests
	localparam int N_FRAMES = 87 + 91;
	localparam int WAIT_CLKS = 6 * `ECHO_IDLE_CLKS + QUIET_CLKS + 3 * GAP_CLKS +
		6 * SETTLE_CLKS;
	localparam int TIMEOUT_CLKS = (N_FRAMES * 11 * CPB + WAIT_CLKS) * 6 / 5;

	logic       sys_clk;
	logic       sys_rst_n;
	logic       uart_rx_line;
	wire        uart_tx_line;
	logic [7:0] got_q[$];
	logic [7:0] exp_q[$];
	logic [7:0] burst[$];
	integer     seed;
	int         cycle_cnt;

	uart_echo_top dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_line (uart_rx_line),
		.uart_tx_line (uart_tx_line)
	);

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// watchdog that also picks up concurrent assertion failures
	initial begin
		cycle_cnt = 0;
		forever begin
			@(posedge sys_clk);
			cycle_cnt++;
			if (cycle_cnt > TIMEOUT_CLKS) begin
				$display("timeout: no complete echo within %0d cycles", TIMEOUT_CLKS);
				abort_run();
			end else if (dut.u_echo_sva.err_cnt != 0) begin
				$display("a concurrent assertion on the transmit path failed");
				abort_run();
			end
		end
	end

	// serial decoder sampling mid-bit on the falling clock edge
	initial begin
		logic [7:0] data;
		wait (sys_rst_n === 1'b1);
		forever begin
			@(negedge uart_tx_line);
			repeat (CPB / 2) @(negedge sys_clk);
			assert (uart_tx_line === 1'b0) else begin
				$display("start bit on the transmit line did not last to mid-bit");
				abort_run();
			end
			for (int i = 0; i < 8; i++) begin
				repeat (CPB) @(negedge sys_clk);
				data[i] = uart_tx_line;
			end
			for (int i = 0; i < `UART_TX_STOP_BITS; i++) begin
				repeat (CPB) @(negedge sys_clk);
				assert (uart_tx_line === 1'b1) else begin
					$display("stop bit %0d of an echo frame was low", i + 1);
					abort_run();
				end
			end
			got_q.push_back(data);
		end
	end

	// 8N1 frame that starts and ends 1 ns after a rising edge
	task automatic send_frame(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rx_line = frame[i];
			repeat (CPB) @(posedge sys_clk);
			#1;
		end
	endtask

	task automatic send_burst(input string name, input int gap);
		@(posedge sys_clk);
		#1;
		foreach (burst[i]) begin
			send_frame(burst[i]);
			if (i < KEEP)
				exp_q.push_back(burst[i]);
			if (gap > 0 && i != burst.size() - 1) begin
				repeat (gap) @(posedge sys_clk);
				#1;
			end
			assert (got_q.size() == 0 && uart_tx_line === 1'b1) else begin
				$display("%s: echo started while the burst was still arriving", name);
				abort_run();
			end
		end
		exp_q.push_back(AMP);
		exp_q.push_back(AMP);
	endtask

	task automatic check_echo(input string name);
		while (got_q.size() < exp_q.size())
			@(posedge sys_clk);
		// an extra frame would finish inside this window
		repeat (SETTLE_CLKS) @(posedge sys_clk);
		assert (got_q.size() == exp_q.size()) else begin
			$display("[ERROR] %s: echo length expected %0d, actual %0d", name,
				exp_q.size(), got_q.size());
			abort_run();
		end
		foreach (exp_q[i]) begin
			assert (got_q[i] === exp_q[i]) else begin
				$display("[ERROR] %s: byte %0d expected %h, actual %h", name, i,
					exp_q[i], got_q[i]);
				abort_run();
			end
		end
		got_q.delete();
		exp_q.delete();
		burst.delete();
	endtask

	initial begin
		seed = 57787;
		sys_rst_n = 1'b0;
		uart_rx_line = 1'b1;
		repeat (4) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;

		// no input, no output
		repeat (QUIET_CLKS) begin
			@(posedge sys_clk);
			#1;
			assert (uart_tx_line === 1'b1 && got_q.size() == 0) else begin
				$display("transmit line moved after reset with no input");
				abort_run();
			end
		end

		burst = '{8'h48, 8'h65, 8'h6c, 8'h6c, 8'h6f};
		send_burst("known_bytes", 0);
		check_echo("known_bytes");

		// gaps well under the idle time
		burst = '{8'h31, 8'h32, 8'h33, 8'h34};
		send_burst("gapped_burst", GAP_CLKS);
		check_echo("gapped_burst");

		for (int i = 0; i < 70; i++)
			burst.push_back(8'($random(seed)));
		send_burst("long_burst", 0);
		check_echo("long_burst");

		burst = '{8'ha1, 8'hb2, 8'hc3, 8'hd4};
		send_burst("first_of_two", 0);
		check_echo("first_of_two");
		burst = '{8'h0f, 8'hf0, 8'h55};
		send_burst("second_of_two", 0);
		check_echo("second_of_two");

		burst = '{8'h5a};
		send_burst("single_byte", 0);
		check_echo("single_byte");

		if (dut.u_echo_sva.err_cnt == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("a concurrent assertion on the transmit path failed");
			abort_run();
		end
	end

endmodule

`default_nettype wire

//--- sim/uart_echo_sva.sv
// Concurrent checks on the controller handshake and the transmit line.
// Bound into the top level; err_cnt counts failures for the testbench.
`timescale 1ns/1ns
`default_nettype none

`include "uart_echo_consts.svh"

module uart_echo_sva (
	input wire                        sys_clk,
	input wire                        sys_rst_n,
	input logic                       tx_req,
	input logic                       tx_done,
	input logic                       tx_line,
	input uart_echo_pkg::echo_state_t state
);

	localparam int CPB = `UART_CLKS_PER_BIT;
	// first stop-bit sample after tx_req: start bit plus 8 data bits
	localparam int STOP_FIRST = 9 * CPB + 1;
	localparam int STOP_CLKS = `UART_TX_STOP_BITS * CPB;

	int err_cnt = 0;

	req_single_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_req |=> !tx_req)
	else begin
		$error("tx_req stayed high for more than one cycle");
		err_cnt++;
	end

	// only one frame in flight at a time
	req_waits_done: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_req |=> (!tx_req throughout tx_done[->1]))
	else begin
		$error("tx_req issued before tx_done of the previous frame");
		err_cnt++;
	end

	stop_bits_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_req |-> ##STOP_FIRST tx_line [*STOP_CLKS])
	else begin
		$error("transmit line low during a stop bit");
		err_cnt++;
	end

	line_quiet_collect: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(state == uart_echo_pkg::ST_IDLE || state == uart_echo_pkg::ST_COLLECT) |-> tx_line)
	else begin
		$error("transmit line active while the controller collects");
		err_cnt++;
	end

endmodule

bind uart_echo_top uart_echo_sva u_echo_sva (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.tx_req    (tx_req),
	.tx_done   (tx_done),
	.tx_line   (uart_tx_line),
	.state     (u_echo_control.state)
);

`default_nettype wire

//--- src/uart_echo_top.sv
// UART string echo subsystem: receiver, line buffer, echo controller and
// transmitter. Bytes of a burst come back on uart_tx_line followed by "&&".
`timescale 1ns/1ns
`default_nettype none

`include "uart_echo_consts.svh"

module uart_echo_top (
	input  wire  sys_clk,
	input  wire  sys_rst_n,
	input  wire  uart_rx_line,
	output logic uart_tx_line
);

	logic [7:0]              rx_data;
	logic                    rx_vld;
	logic                    buf_we;
	logic                    buf_re;
	uart_echo_pkg::buf_idx_t buf_addr;
	logic [7:0]              buf_wdata;
	logic [7:0]              buf_rdata;
	logic                    tx_req;
	logic [7:0]              tx_data;
	logic                    tx_done;

	uart_rx #(
		.CLKS_PER_BIT (`UART_CLKS_PER_BIT),
		.STOP_BITS    (`UART_RX_STOP_BITS)
	) u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_line),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld)
	);

	line_buffer u_line_buffer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.we        (buf_we),
		.re        (buf_re),
		.addr      (buf_addr),
		.wdata     (buf_wdata),
		.rdata     (buf_rdata)
	);

	echo_control u_echo_control (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld),
		.buf_we    (buf_we),
		.buf_re    (buf_re),
		.buf_addr  (buf_addr),
		.buf_wdata (buf_wdata),
		.buf_rdata (buf_rdata),
		.tx_req    (tx_req),
		.tx_data   (tx_data),
		.tx_done   (tx_done)
	);

	uart_tx #(
		.CLKS_PER_BIT (`UART_CLKS_PER_BIT),
		.STOP_BITS    (`UART_TX_STOP_BITS)
	) u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (tx_data),
		.tx_req    (tx_req),
		.tx        (uart_tx_line),
		.tx_done   (tx_done)
	);

endmodule

`default_nettype wire

//--- src/echo_control.sv
// Echo controller. Collects received bytes into the line buffer, and after
// ECHO_IDLE_CLKS of silence appends two markers and sends the line back
// one byte per tx_req/tx_done handshake.
`timescale 1ns/1ns
`default_nettype none

`include "uart_echo_consts.svh"

module echo_control (
	input  wire                     sys_clk,
	input  wire                     sys_rst_n,
	input  logic [7:0]              rx_data,
	input  logic                    rx_vld,
	output logic                    buf_we,
	output logic                    buf_re,
	output uart_echo_pkg::buf_idx_t buf_addr,
	output logic [7:0]              buf_wdata,
	input  logic [7:0]              buf_rdata,
	output logic                    tx_req,
	output logic [7:0]              tx_data,
	input  logic                    tx_done
);

	// two entries stay free for the markers
	localparam uart_echo_pkg::buf_idx_t FILL_MAX =
		uart_echo_pkg::buf_idx_t'(`ECHO_BUF_DEPTH - 2);
	localparam int IDLE_W = $clog2(`ECHO_IDLE_CLKS);
	localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(`ECHO_IDLE_CLKS - 1);

	uart_echo_pkg::echo_state_t state;
	uart_echo_pkg::buf_idx_t    count;
	uart_echo_pkg::buf_idx_t    rd_idx;
	logic [IDLE_W-1:0]          idle_cnt;
	logic                       accepting;
	logic                       rx_store;
	logic                       timeout;
	logic                       last_byte;

	assign accepting = (state == uart_echo_pkg::ST_IDLE) ||
		(state == uart_echo_pkg::ST_COLLECT);
	assign rx_store  = accepting && rx_vld && (count < FILL_MAX);
	assign timeout   = (state == uart_echo_pkg::ST_COLLECT) && !rx_vld &&
		(idle_cnt == IDLE_LAST);
	assign last_byte = (uart_echo_pkg::buf_idx_t'(rd_idx + 1'b1) == count);

	// first marker on the timeout cycle, second one in mark
	assign buf_we    = rx_store || timeout || (state == uart_echo_pkg::ST_MARK);
	assign buf_wdata = rx_store ? rx_data : `ECHO_MARKER;
	// send owns the address, every other state writes at the count
	assign buf_addr  = (state == uart_echo_pkg::ST_SEND) ? rd_idx : count;

	// rdata stays put until the next read, well past the tx_req pulse
	assign tx_data   = buf_rdata;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= uart_echo_pkg::ST_IDLE;
			count    <= '0;
			rd_idx   <= '0;
			idle_cnt <= '0;
			buf_re   <= 1'b0;
			tx_req   <= 1'b0;
		end else begin
			buf_re <= 1'b0;
			// read data is ready one cycle after the read
			tx_req <= buf_re;
			if (buf_we)
				count <= count + 1'b1;
			case (state)
				uart_echo_pkg::ST_IDLE: begin
					idle_cnt <= '0;
					if (rx_vld)
						state <= uart_echo_pkg::ST_COLLECT;
				end
				uart_echo_pkg::ST_COLLECT: begin
					// dropped bytes still count as line activity
					if (rx_vld)
						idle_cnt <= '0;
					else if (timeout)
						state <= uart_echo_pkg::ST_MARK;
					else
						idle_cnt <= idle_cnt + 1'b1;
				end
				uart_echo_pkg::ST_MARK: begin
					buf_re <= 1'b1;
					state  <= uart_echo_pkg::ST_SEND;
				end
				uart_echo_pkg::ST_SEND: begin
					if (tx_done) begin
						if (last_byte) begin
							count <= '0;
							state <= uart_echo_pkg::ST_FINISH;
						end else begin
							rd_idx <= rd_idx + 1'b1;
							buf_re <= 1'b1;
						end
					end
				end
				uart_echo_pkg::ST_FINISH: begin
					rd_idx <= '0;
					state  <= uart_echo_pkg::ST_IDLE;
				end
				default: state <= uart_echo_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/line_buffer.sv
// Single-port byte buffer for the echo line.
// Write on the edge where we is high; rdata is valid the cycle after re.
`timescale 1ns/1ns
`default_nettype none

`include "uart_echo_consts.svh"

module line_buffer (
	input  wire                     sys_clk,
	input  wire                     sys_rst_n,
	input  logic                    we,
	input  logic                    re,
	input  uart_echo_pkg::buf_idx_t addr,
	input  logic [7:0]              wdata,
	output logic [7:0]              rdata
);

	localparam int AW = $clog2(`ECHO_BUF_DEPTH);

	logic [7:0] mem [`ECHO_BUF_DEPTH];

	// the controller never addresses past the last entry
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < `ECHO_BUF_DEPTH; i++)
				mem[i] <= '0;
			rdata <= '0;
		end else begin
			if (we)
				mem[addr[AW-1:0]] <= wdata;
			if (re)
				rdata <= mem[addr[AW-1:0]];
		end
	end

endmodule

`default_nettype wire

//--- src/uart_tx.sv
// Serial transmitter: start bit, 8 data bits LSB first, STOP_BITS stop bits.
// tx_req is taken only while idle and latches tx_data; tx_done pulses
// once at the end of the last stop bit.
`timescale 1ns/1ns
`default_nettype none

`include "uart_echo_consts.svh"

module uart_tx #(
	parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT,
	parameter int STOP_BITS    = `UART_TX_STOP_BITS
) (
	input  wire         sys_clk,
	input  wire         sys_rst_n,
	input  logic [7:0]  tx_data,
	input  logic        tx_req,
	output logic        tx,
	output logic        tx_done
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
	// bit 0 is the start bit, the last stop bit follows the 8 data bits
	localparam logic [3:0] LAST_BIT = 4'(8 + STOP_BITS);

	logic             busy;
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0]       bit_cnt;
	logic [7:0]       shift_reg;
	logic             bit_tick;

	assign bit_tick = busy && (baud_cnt == FULL_BIT);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			tx       <= 1'b1;
			tx_done  <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (!busy) begin
				if (tx_req) begin
					busy     <= 1'b1;
					baud_cnt <= '0;
					bit_cnt  <= '0;
					tx       <= 1'b0;
				end
			end else if (bit_tick) begin
				baud_cnt <= '0;
				if (bit_cnt == LAST_BIT) begin
					busy    <= 1'b0;
					tx_done <= 1'b1;
					tx      <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
					tx      <= shift_reg[0];
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// ones shifted in from the top become the stop bits
	always_ff @(posedge sys_clk) begin
		if (!busy && tx_req)
			shift_reg <= tx_data;
		else if (bit_tick)
			shift_reg <= {1'b1, shift_reg[7:1]};
	end

endmodule

`default_nettype wire

//--- src/uart_rx.sv
// Serial receiver, 8 data bits LSB first, no parity.
// Pulses rx_vld for one cycle in the middle of the last stop bit;
// rx_data holds the byte until the next rx_vld.
`timescale 1ns/1ns
`default_nettype none

`include "uart_echo_consts.svh"

module uart_rx #(
	parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT,
	parameter int STOP_BITS    = `UART_RX_STOP_BITS
) (
	input  wire         sys_clk,
	input  wire         sys_rst_n,
	input  logic        rx,
	output logic [7:0]  rx_data,
	output logic        rx_vld
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [3:0] LAST_STOP = 4'(STOP_BITS - 1);

	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_START = 2'd1;
	localparam logic [1:0] S_DATA  = 2'd2;
	localparam logic [1:0] S_STOP  = 2'd3;

	logic             rx_meta;
	logic             rx_sync;
	logic [1:0]       state;
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0]       bit_cnt;
	logic             stop_ok;
	logic [7:0]       shift_reg;
	logic             bit_tick;

	// two-flop synchronizer that resets to the idle-high level
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// after the half-bit start phase every tick lands mid-bit
	assign bit_tick = (baud_cnt == FULL_BIT);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= S_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			stop_ok  <= 1'b0;
			rx_data  <= '0;
			rx_vld   <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			case (state)
				S_IDLE: begin
					baud_cnt <= '0;
					bit_cnt  <= '0;
					if (!rx_sync)
						state <= S_START;
				end
				S_START: begin
					if (baud_cnt == HALF_BIT) begin
						baud_cnt <= '0;
						// a glitch that is gone by mid start bit is ignored
						state <= rx_sync ? S_IDLE : S_DATA;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (bit_tick) begin
						baud_cnt <= '0;
						if (bit_cnt == 4'd7) begin
							bit_cnt <= '0;
							stop_ok <= 1'b1;
							state   <= S_STOP;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: begin
					if (bit_tick) begin
						baud_cnt <= '0;
						if (bit_cnt == LAST_STOP) begin
							// framing error drops the byte
							rx_vld <= stop_ok & rx_sync;
							if (stop_ok & rx_sync)
								rx_data <= shift_reg;
							state <= S_IDLE;
						end else begin
							stop_ok <= stop_ok & rx_sync;
							bit_cnt <= bit_cnt + 1'b1;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge sys_clk) begin
		if (state == S_DATA && bit_tick)
			shift_reg <= {rx_sync, shift_reg[7:1]};
	end

endmodule

`default_nettype wire

//--- src/uart_echo_pkg.sv
// Types shared by the echo controller, the line buffer and the top level.
// Referenced by scoped name only.
`default_nettype none

`include "uart_echo_consts.svh"

package uart_echo_pkg;

	// controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_COLLECT,
		ST_MARK,
		ST_SEND,
		ST_FINISH
	} echo_state_t;

	// index and byte count, one bit wider so a full count fits
	typedef logic [$clog2(`ECHO_BUF_DEPTH + 1) - 1 : 0] buf_idx_t;

endpackage

`default_nettype wire

//--- src/uart_echo_consts.svh
// Build constants for the UART echo subsystem.
// Included by every RTL file and by the testbench files; the include
// directory is given on the compile file list.
`ifndef UART_ECHO_CONSTS_SVH
`define UART_ECHO_CONSTS_SVH

// system clocks per serial bit
`define UART_CLKS_PER_BIT 8

// 8N1 on receive, two stop bits on transmit
`define UART_RX_STOP_BITS 1
`define UART_TX_STOP_BITS 2

// three byte times of silence ends a burst
`define ECHO_IDLE_CLKS 240

`define ECHO_BUF_DEPTH 64

// ascii ampersand
`define ECHO_MARKER 8'h26

`endif
